// File: vlog.f
rtl/sdmac_pkg.sv
rtl/cpu_term_if.sv
rtl/cpu_ctl_if.sv
rtl/cpu_term_decode.sv
rtl/cpu_sm_execute.sv
rtl/cpu_strobe_result.sv
rtl/cpu_sm.sv
tb/tb_clock.sv
tb/tb_cpu_sm.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_cpu_sm
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Simulation PASSED
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_cpu_sm.sv
// One word per table row with a single slave answer per pds; 16-bit rows from the bus start on a1 low
module tb_cpu_sm;

    logic CLK90;
    logic CCRESET_;
    logic dmaena, dmadir, dreq_, bgrant_, fifoempty, fifofull, flushfifo, a1;
    logic dsack0_ = 1'b1;
    logic dsack1_ = 1'b1;
    logic sterm_ = 1'b1;
    logic [31:0] fifo_rdata;
    logic [31:0] bus_rdata = '0;
    logic breq, bgack, pas, pds, size1, f2cpu, incfifo, decfifo, incno, stopflush;
    logic [31:0] bus_wdata, fifo_wdata;

    // Row fields are dir (1 = FIFO to bus), port16, a1, flush, sterm and slave delay
    logic [7:0] rows [6];
    sdmac_pkg::fifo_word_u cur_word;
    logic cur_dir, cur_port16, cur_a1, cur_flush, cur_sterm;
    int cur_delay;
    int slave_wait = 0;
    int pass_cnt = 0;
    logic answered = 1'b0;
    logic [15:0] lfsr;
    logic [31:0] rnd;
    int errors, checks, row_errs, n, passes, rises, n_incno, n_dec, n_inc;
    logic prev_pds;

    tb_clock i_clock (.CLK90(CLK90), .CCRESET_(CCRESET_));

    cpu_sm i_cpu_sm (.*);

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // Half seen on data bits 31..16 during a given pass of a 16-bit transfer
    function automatic logic [15:0] half_for_pass(input int p);
        return (cur_a1 || p != 0) ? cur_word.halves.lo : cur_word.halves.hi;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
            row_errs++;
        end
    endtask

    task automatic give_up(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Simulation FAILED");
        $finish;
    endtask

    // Slave answers pds after the row delay and holds its answer until pds drops
    always @(posedge CLK90) begin
        if (!bgack) begin
            pass_cnt <= 0;
        end
        if (!pds) begin
            dsack0_    <= 1'b1;
            dsack1_    <= 1'b1;
            sterm_     <= 1'b1;
            slave_wait <= 0;
            answered   <= 1'b0;
        end else if (!answered) begin
            if (slave_wait == cur_delay) begin
                answered <= 1'b1;
                pass_cnt <= pass_cnt + 1;
                if (cur_sterm) begin
                    sterm_ <= 1'b0;
                end else begin
                    dsack1_ <= 1'b0;
                    dsack0_ <= cur_port16;
                end
                if (cur_port16) begin
                    bus_rdata <= {half_for_pass(pass_cnt), ~half_for_pass(pass_cnt)};
                end else begin
                    bus_rdata <= cur_word.long;
                end
            end else begin
                slave_wait <= slave_wait + 1;
            end
        end
    end

    initial begin
        dmaena = 1'b0;
        dmadir = 1'b0;
        dreq_ = 1'b1;
        bgrant_ = 1'b1;
        fifoempty = 1'b0;
        fifofull = 1'b0;
        flushfifo = 1'b0;
        a1 = 1'b0;
        fifo_rdata = '0;
        cur_word = '0;
        {cur_dir, cur_port16, cur_a1, cur_flush, cur_sterm} = '0;
        cur_delay = 0;
        lfsr = 16'd4088;
        errors = 0;
        checks = 0;
        rows[0] = 8'b1000_0001;
        rows[1] = 8'b1100_0000;
        rows[2] = 8'b0100_0010;
        rows[3] = 8'b0000_1000;
        rows[4] = 8'b1110_0001;
        rows[5] = 8'b0001_0000;

        // Quiet outputs through and after reset
        row_errs = 0;
        repeat (6) begin
            @(posedge CLK90);
            check_val("control outputs", 32'({breq, bgack, pas, pds, size1, f2cpu,
                      incfifo, decfifo, incno, stopflush}), 32'd0);
        end
        $display("Reset check: %0d errors", row_errs);

        for (int r = 0; r < 6; r++) begin
            row_errs = 0;
            {cur_dir, cur_port16, cur_a1, cur_flush, cur_sterm} = rows[r][7:3];
            cur_delay = int'(rows[r][2:0]);
            take_bits(32, rnd);
            cur_word.long = rnd;
            passes = (cur_port16 && !cur_a1) ? 2 : 1;
            @(posedge CLK90);
            dmaena <= 1'b1;
            dmadir <= cur_dir;
            dreq_ <= 1'b0;
            if (cur_flush) begin
                flushfifo <= 1'b1;
                fifoempty <= 1'b1;
                n = 0;
                do begin
                    @(posedge CLK90);
                    check_val("pas", 32'(pas), 32'd0);
                    check_val("breq", 32'(breq), 32'd0);
                    n++;
                    if (n > 20) give_up("stopflush");
                end while (!stopflush);
                // Flush still held, so the sequencer must stay off the bus
                repeat (4) begin
                    @(posedge CLK90);
                    check_val("breq", 32'(breq), 32'd0);
                    check_val("pas", 32'(pas), 32'd0);
                    check_val("stopflush", 32'(stopflush), 32'd0);
                end
                flushfifo <= 1'b0;
                fifoempty <= 1'b0;
                dreq_ <= 1'b1;
            end else begin
                fifo_rdata <= cur_word.long;
                a1 <= cur_a1;
                n = 0;
                do begin
                    @(posedge CLK90);
                    check_val("pas", 32'(pas), 32'd0);
                    n++;
                    if (n > 20) give_up("breq");
                end while (!breq);
                // Grant withheld for a random time
                take_bits(4, rnd);
                repeat (int'(rnd)) begin
                    @(posedge CLK90);
                    check_val("breq", 32'(breq), 32'd1);
                    check_val("pas", 32'(pas), 32'd0);
                end
                bgrant_ <= 1'b0;
                n = 0;
                do begin
                    @(posedge CLK90);
                    n++;
                    if (n > 30) give_up("pas after grant");
                end while (!pas);
                dreq_ <= 1'b1;
                n_incno = int'(incno);
                {rises, n_dec, n_inc, n} = '0;
                prev_pds = 1'b0;
                do begin
                    @(posedge CLK90);
                    if (pds && !prev_pds) rises++;
                    if (pds) begin
                        check_val("size1", 32'(size1), 32'd1);
                        check_val("f2cpu", 32'(f2cpu), 32'(cur_dir));
                        check_val("bgack", 32'(bgack), 32'd1);
                        if (cur_dir && !cur_port16) begin
                            check_val("bus_wdata", bus_wdata, cur_word.long);
                        end else if (cur_dir) begin
                            check_val("bus_wdata[31:16]", 32'(bus_wdata[31:16]),
                                      32'(half_for_pass(rises - 1)));
                        end
                    end
                    if (incno) n_incno++;
                    if (decfifo) n_dec++;
                    if (incfifo) begin
                        n_inc++;
                        check_val("fifo_wdata", fifo_wdata, cur_word.long);
                    end
                    prev_pds = pds;
                    n++;
                    if (n > 200) give_up("bus release");
                end while (bgack);
                bgrant_ <= 1'b1;
                check_val("pds cycles", 32'(rises), 32'(passes));
                check_val("incno pulses", 32'(n_incno), 32'(passes));
                check_val("decfifo pulses", 32'(n_dec), 32'(cur_dir));
                check_val("incfifo pulses", 32'(n_inc), 32'(!cur_dir));
            end
            repeat (4) @(posedge CLK90);
            $display("Row %0d dir=%0b port16=%0b a1=%0b flush=%0b: %0d errors",
                     r, cur_dir, cur_port16, cur_a1, cur_flush, row_errs);
        end

        $display("Rows 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock.sv
// Free-running CLK90 with a period of 100; CCRESET_ is held low for the first 3 rising edges
module tb_clock (
    output logic CLK90,
    output logic CCRESET_
);

    initial begin
        CLK90 = 1'b0;
        forever begin
            #50 CLK90 = ~CLK90;
        end
    end

    initial begin
        CCRESET_ = 1'b0;
        repeat (3) @(posedge CLK90);
        CCRESET_ <= 1'b1;
    end

endmodule

// File: rtl/cpu_sm.sv
// Everything runs on CLK90; address register, FIFO and SCSI side sit outside this block
module cpu_sm (
    input  logic CLK90,
    input  logic CCRESET_,
    input  logic dmaena,
    input  logic dmadir,
    input  logic dreq_,
    input  logic bgrant_,
    input  logic fifoempty,
    input  logic fifofull,
    input  logic flushfifo,
    input  logic dsack0_,
    input  logic dsack1_,
    input  logic sterm_,
    input  logic a1,
    input  logic [sdmac_pkg::data_w-1:0] fifo_rdata,
    input  logic [sdmac_pkg::data_w-1:0] bus_rdata,
    output logic breq,
    output logic bgack,
    output logic pas,
    output logic pds,
    output logic size1,
    output logic f2cpu,
    output logic incfifo,
    output logic decfifo,
    output logic incno,
    output logic stopflush,
    output logic [sdmac_pkg::data_w-1:0] bus_wdata,
    output logic [sdmac_pkg::data_w-1:0] fifo_wdata
);

    cpu_term_if term_if ();
    cpu_ctl_if  ctl_if ();

    cpu_term_decode i_decode (
        .CLK90      (CLK90),
        .CCRESET_   (CCRESET_),
        .dmaena     (dmaena),
        .dmadir     (dmadir),
        .dreq_      (dreq_),
        .bgrant_    (bgrant_),
        .fifoempty  (fifoempty),
        .fifofull   (fifofull),
        .flushfifo  (flushfifo),
        .dsack0_    (dsack0_),
        .dsack1_    (dsack1_),
        .sterm_     (sterm_),
        .strobe_out (pds),
        .term       (term_if.decode_mp)
    );

    cpu_sm_execute i_execute (
        .CLK90    (CLK90),
        .CCRESET_ (CCRESET_),
        .dmadir   (dmadir),
        .a1       (a1),
        .term     (term_if.execute_mp),
        .ctl      (ctl_if.execute_mp)
    );

    cpu_strobe_result i_result (
        .CLK90      (CLK90),
        .CCRESET_   (CCRESET_),
        .ctl        (ctl_if.result_mp),
        .fifo_rdata (fifo_rdata),
        .bus_rdata  (bus_rdata),
        .breq       (breq),
        .bgack      (bgack),
        .pas        (pas),
        .pds        (pds),
        .size1      (size1),
        .f2cpu      (f2cpu),
        .incfifo    (incfifo),
        .decfifo    (decfifo),
        .incno      (incno),
        .stopflush  (stopflush),
        .bus_wdata  (bus_wdata),
        .fifo_wdata (fifo_wdata)
    );

endmodule

// File: rtl/cpu_strobe_result.sv
// All strobes lag the state by one CLK90; 16-bit ports are assumed wired to data bits 31 to 16
module cpu_strobe_result (
    input  logic CLK90,
    input  logic CCRESET_,
    cpu_ctl_if.result_mp ctl,
    input  logic [sdmac_pkg::data_w-1:0] fifo_rdata,
    input  logic [sdmac_pkg::data_w-1:0] bus_rdata,
    output logic breq,
    output logic bgack,
    output logic pas,
    output logic pds,
    output logic size1,
    output logic f2cpu,
    output logic incfifo,
    output logic decfifo,
    output logic incno,
    output logic stopflush,
    output logic [sdmac_pkg::data_w-1:0] bus_wdata,
    output logic [sdmac_pkg::data_w-1:0] fifo_wdata
);

    sdmac_pkg::fifo_word_u tx_word;
    sdmac_pkg::fifo_word_u rx_word;

    logic in_addr;
    logic in_data;
    logic own_bus;

    assign in_addr = (ctl.state == sdmac_pkg::ADDR);
    assign in_data = (ctl.state == sdmac_pkg::DATA);

    // Bus is held from grant until release
    assign own_bus = (ctl.state == sdmac_pkg::BUS_OWN) || in_addr || in_data ||
                     (ctl.state == sdmac_pkg::NEXT_HALF) ||
                     (ctl.state == sdmac_pkg::WORD_END);

    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            breq      <= 1'b0;
            bgack     <= 1'b0;
            pas       <= 1'b0;
            pds       <= 1'b0;
            size1     <= 1'b0;
            f2cpu     <= 1'b0;
            incfifo   <= 1'b0;
            decfifo   <= 1'b0;
            incno     <= 1'b0;
            stopflush <= 1'b0;
        end else begin
            breq      <= (ctl.state == sdmac_pkg::BUS_REQ);
            bgack     <= own_bus;
            pas       <= in_addr | in_data;
            pds       <= in_data;
            // Word-sized request on every pass, a 32-bit port answers for the long
            size1     <= in_addr | in_data;
            f2cpu     <= ctl.dir & (in_addr | in_data);
            incno     <= in_addr;
            decfifo   <= ctl.word_end & ctl.dir;
            incfifo   <= ctl.word_end & ~ctl.dir;
            stopflush <= ctl.flush_stop;
        end
    end

    assign tx_word.long = fifo_rdata;

    // Low half goes out on both bus halves
    always_ff @(posedge CLK90) begin
        if (ctl.half_lo) begin
            bus_wdata <= {tx_word.halves.lo, tx_word.halves.lo};
        end else begin
            bus_wdata <= tx_word.long;
        end
    end

    // Slave data is still held in the cycle after termination
    always_ff @(posedge CLK90) begin
        if (!ctl.dir) begin
            if (ctl.state == sdmac_pkg::NEXT_HALF) begin
                rx_word.halves.hi <= bus_rdata[sdmac_pkg::data_w-1:sdmac_pkg::half_w];
            end else if (ctl.word_end && ctl.half_lo) begin
                rx_word.halves.lo <= bus_rdata[sdmac_pkg::data_w-1:sdmac_pkg::half_w];
            end else if (ctl.word_end) begin
                rx_word.long <= bus_rdata;
            end
        end
    end

    assign fifo_wdata = rx_word.long;

endmodule

// File: rtl/cpu_sm_execute.sv
// One word per bus tenure step; a 16-bit port with a1 low takes two passes, no retry or burst
module cpu_sm_execute (
    input  logic CLK90,
    input  logic CCRESET_,
    input  logic dmadir,
    input  logic a1,
    cpu_term_if.execute_mp term,
    cpu_ctl_if.execute_mp  ctl
);

    sdmac_pkg::state_e state_q;
    sdmac_pkg::state_e state_d;

    logic [sdmac_pkg::own_wait_w-1:0] own_cnt;
    logic own_ready;
    logic half_lo_q;
    logic dir_q;
    logic last_seen;

    assign own_ready = (own_cnt == sdmac_pkg::own_wait);

    always_comb begin
        state_d = state_q;
        case (state_q)
            sdmac_pkg::IDLE: begin
                if (term.start_ok && !term.last_word) begin
                    state_d = sdmac_pkg::BUS_REQ;
                end
            end
            sdmac_pkg::BUS_REQ: begin
                if (term.grant) begin
                    state_d = sdmac_pkg::BUS_OWN;
                end
            end
            sdmac_pkg::BUS_OWN: begin
                // Wait for the FIFO flags to settle before the next word
                if (own_ready) begin
                    state_d = term.start_ok ? sdmac_pkg::ADDR : sdmac_pkg::RELEASE;
                end
            end
            sdmac_pkg::ADDR: begin
                state_d = sdmac_pkg::DATA;
            end
            sdmac_pkg::DATA: begin
                if (term.term) begin
                    // A 16-bit port still owes the low half
                    if (term.port16 == sdmac_pkg::PORT16 && !half_lo_q) begin
                        state_d = sdmac_pkg::NEXT_HALF;
                    end else begin
                        state_d = sdmac_pkg::WORD_END;
                    end
                end
            end
            sdmac_pkg::NEXT_HALF: begin
                state_d = sdmac_pkg::ADDR;
            end
            sdmac_pkg::WORD_END: begin
                state_d = term.start_ok ? sdmac_pkg::BUS_OWN : sdmac_pkg::RELEASE;
            end
            sdmac_pkg::RELEASE: begin
                state_d = sdmac_pkg::IDLE;
            end
            default: begin
                state_d = sdmac_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state_q   <= sdmac_pkg::IDLE;
            own_cnt   <= '0;
            half_lo_q <= 1'b0;
            dir_q     <= 1'b0;
            last_seen <= 1'b0;
        end else begin
            state_q   <= state_d;
            last_seen <= term.last_word;

            // Direction is fixed for the whole bus tenure
            if (state_q == sdmac_pkg::BUS_REQ) begin
                dir_q <= dmadir;
            end

            if (state_q == sdmac_pkg::BUS_OWN) begin
                if (!own_ready) begin
                    own_cnt <= own_cnt + 1'b1;
                end
            end else begin
                own_cnt <= '0;
            end

            // An odd word address starts on the low half
            if (state_q == sdmac_pkg::BUS_OWN) begin
                half_lo_q <= a1;
            end else if (state_q == sdmac_pkg::NEXT_HALF) begin
                half_lo_q <= 1'b1;
            end
        end
    end

    assign ctl.state    = state_q;
    assign ctl.half_lo  = half_lo_q;
    assign ctl.dir      = dir_q;
    assign ctl.word_end = (state_q == sdmac_pkg::WORD_END);

    // Flush ends once, on the first idle cycle that sees the FIFO drained
    assign ctl.flush_stop = (state_q == sdmac_pkg::IDLE) & term.last_word & ~last_seen;

endmodule

// File: rtl/cpu_term_decode.sv
// Inputs take two CLK90 flops of latency; DSACK0 alone counts as a 16-bit port, bus errors ignored
module cpu_term_decode (
    input  logic CLK90,
    input  logic CCRESET_,
    input  logic dmaena,
    input  logic dmadir,
    input  logic dreq_,
    input  logic bgrant_,
    input  logic fifoempty,
    input  logic fifofull,
    input  logic flushfifo,
    input  logic dsack0_,
    input  logic dsack1_,
    input  logic sterm_,
    input  logic strobe_out,
    cpu_term_if.decode_mp term
);

    // Active-high view of the asynchronous inputs and its two synchronizer stages
    logic [9:0] sync_in;
    logic [9:0] sync_1;
    logic [9:0] sync_2;

    logic dmaena_s;
    logic dmadir_s;
    logic dreq_s;
    logic bgrant_s;
    logic empty_s;
    logic full_s;
    logic flush_s;
    logic dsack0_s;
    logic dsack1_s;
    logic sterm_s;

    logic ack_s;
    logic ack_seen;
    logic ack_first;

    assign sync_in = {dmaena, dmadir, ~dreq_, ~bgrant_, fifoempty,
                      fifofull, flushfifo, ~dsack0_, ~dsack1_, ~sterm_};

    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= sync_in;
            sync_2 <= sync_1;
        end
    end

    assign {dmaena_s, dmadir_s, dreq_s, bgrant_s, empty_s,
            full_s, flush_s, dsack0_s, dsack1_s, sterm_s} = sync_2;

    // Any form of termination from the slave
    assign ack_s = dsack0_s | dsack1_s | sterm_s;

    // Only the first acknowledged cycle counts; the slave holds its answer until pds drops
    assign ack_first = ack_s & strobe_out & ~ack_seen;

    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            ack_seen    <= 1'b0;
            term.term   <= 1'b0;
            term.port16 <= sdmac_pkg::PORT32;
        end else begin
            ack_seen  <= ack_s & (ack_seen | strobe_out);
            term.term <= ack_first;
            if (ack_first) begin
                // Both DSACK lines or STERM mean a full 32-bit port
                if ((dsack0_s && dsack1_s) || sterm_s) begin
                    term.port16 <= sdmac_pkg::PORT32;
                end else begin
                    term.port16 <= sdmac_pkg::PORT16;
                end
            end
        end
    end

    // FIFO must have a word to give, or room to take one
    assign term.start_ok  = dmaena_s & dreq_s & (dmadir_s ? ~empty_s : ~full_s);
    assign term.grant     = bgrant_s;
    assign term.last_word = flush_s & empty_s;

endmodule

// File: rtl/cpu_ctl_if.sv
// Execute to result signals; word_end and flush_stop are single-cycle pulses on CLK90
interface cpu_ctl_if;

    // Current sequencer state
    sdmac_pkg::state_e state;

    // Low half is the active half of a 16-bit transfer
    logic half_lo;

    // High moves FIFO to bus, low moves bus to FIFO
    logic dir;

    logic word_end;
    logic flush_stop;

    modport execute_mp (
        output state,
        output half_lo,
        output dir,
        output word_end,
        output flush_stop
    );

    modport result_mp (
        input state,
        input half_lo,
        input dir,
        input word_end,
        input flush_stop
    );

endinterface

// File: rtl/cpu_term_if.sv
// Decode to execute signals; all fields are synchronous to CLK90, term is a single-cycle pulse
interface cpu_term_if;

    // Bus cycle termination seen while the data strobe is out
    logic term;

    // Port size captured together with term
    sdmac_pkg::port_e port16;

    // Conditions for starting and stopping transfers
    logic start_ok;
    logic grant;
    logic last_word;

    modport decode_mp (
        output term,
        output port16,
        output start_ok,
        output grant,
        output last_word
    );

    modport execute_mp (
        input term,
        input port16,
        input start_ok,
        input grant,
        input last_word
    );

endinterface

// File: rtl/sdmac_pkg.sv
// Shared widths and types for the CPU bus sequencer; 8-bit ports, bus errors and bursts not modelled
package sdmac_pkg;

    // FIFO word and CPU data bus width
    localparam int data_w = 32;

    // One half of the word, as moved over a 16-bit port
    localparam int half_w = data_w / 2;

    // Settle time in BUS_OWN so the synchronized FIFO flags catch up
    localparam int own_wait_w = 2;
    localparam logic [own_wait_w-1:0] own_wait = 3;

    // Sequencer states
    typedef enum logic [4:0] {
        IDLE,
        BUS_REQ,
        BUS_OWN,
        ADDR,
        DATA,
        NEXT_HALF,
        WORD_END,
        RELEASE
    } state_e;

    // Size of the answering port, taken from DSACK/STERM
    typedef enum logic {
        PORT32 = 1'b0,
        PORT16 = 1'b1
    } port_e;

    // One FIFO word, seen whole for a 32-bit port or as two halves for a 16-bit port
    typedef union packed {
        logic [data_w-1:0] long;
        struct packed {
            logic [half_w-1:0] hi;
            logic [half_w-1:0] lo;
        } halves;
    } fifo_word_u;

endpackage
